// File: Bender.yml
package:
  name: cnn_accel

sources:
  - include_dirs:
      - .
    files:
      - cnn_pkg.sv
      - conv_ctrl_if.sv
      - conv_sequencer.sv
      - kernel_loader.sv
      - window_buffer.sv
      - conv_datapath.sv
      - pool_writer.sv
      - cnn_accel_top.sv
      - target: test
        files:
          - cnn_accel_chk.sv
          - tb_cnn_accel.sv

// File: cnn_accel_chk.sv
`default_nettype none

module cnn_accel_chk import cnn_pkg::*; (
    input wire             clk,
    input wire             reset_b,
    input wire             dut_run,
    input wire             dut_busy,
    input wire             output_write_enable,
    input wire addr_t      output_write_address,
    input wire seq_state_t state
);

    addr_t next_addr;          // where the next write of this run lands
    int    error_count = 0;    // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset_b || !dut_busy) next_addr <= '0;
        else if (output_write_enable) next_addr <= next_addr + 1'b1;
    end

    // ----------------------------------------
    // output write port
    // ----------------------------------------
    write_while_busy: assert property (@(posedge clk) disable iff (reset_b)
        output_write_enable |-> dut_busy)
        else begin
            $error("output write while dut_busy is low");
            error_count++;
        end

    address_step: assert property (@(posedge clk) disable iff (reset_b)
        output_write_enable |-> output_write_address == next_addr)
        else begin
            $error("output address did not step by one");
            error_count++;
        end

    // ----------------------------------------
    // busy protocol
    // ----------------------------------------
    busy_rise: assert property (@(posedge clk) disable iff (reset_b)
        $rose(dut_busy) |-> $past(dut_run))
        else begin
            $error("dut_busy rose without dut_run");
            error_count++;
        end

    busy_active: assert property (@(posedge clk) disable iff (reset_b)
        (state != s_idle) |-> dut_busy)
        else begin
            $error("sequencer active while dut_busy is low");
            error_count++;
        end

    busy_fall: assert property (@(posedge clk) disable iff (reset_b)
        $fell(dut_busy) |-> state == s_idle)
        else begin
            $error("dut_busy fell outside idle");
            error_count++;
        end

endmodule

bind cnn_accel_top cnn_accel_chk u_chk (
    .clk(clk), .reset_b(reset_b), .dut_run(dut_run), .dut_busy(dut_busy),
    .output_write_enable(output_write_enable),
    .output_write_address(output_write_address),
    .state(u_sequencer.state)
);

`default_nettype wire

// File: cnn_accel_top.sv
`default_nettype none

module cnn_accel_top import cnn_pkg::*; (
    input  wire         clk,
    input  wire         reset_b,
    input  wire         dut_run,
    output logic        dut_busy,
    // input sram
    output logic        input_write_enable,
    output addr_t       input_write_address, input_read_address,
    output word_t       input_write_data,
    input  wire word_t  input_read_data,
    // weights sram
    output logic        weights_write_enable,
    output addr_t       weights_write_address, weights_read_address,
    output word_t       weights_write_data,
    input  wire word_t  weights_read_data,
    // output sram, write side only in use
    output logic        output_write_enable,
    output addr_t       output_write_address, output_read_address,
    output word_t       output_write_data,
    input  wire word_t  output_read_data
);

    logic      kernel_start, kernel_done;
    kernel_t   kernel;
    window_t   window;
    acc_quad_t acc;

    conv_ctrl_if u_ctrl ();

    // input and weights are read-only here
    assign input_write_enable = 1'b0;
    assign input_write_address = '0;
    assign input_write_data = '0;
    assign weights_write_enable = 1'b0;
    assign weights_write_address = '0;
    assign weights_write_data = '0;
    assign output_read_address = '0;

    conv_sequencer u_sequencer (
        .clk(clk), .reset_b(reset_b), .dut_run(dut_run), .kernel_done(kernel_done),
        .input_read_data(input_read_data), .input_read_address(input_read_address),
        .kernel_start(kernel_start), .dut_busy(dut_busy), .ctrl(u_ctrl.seq)
    );

    kernel_loader u_kernel_loader (
        .clk(clk), .reset_b(reset_b), .start(kernel_start),
        .weights_read_data(weights_read_data), .weights_read_address(weights_read_address),
        .done(kernel_done), .kernel(kernel)
    );

    window_buffer u_window_buffer (
        .clk(clk), .reset_b(reset_b), .row_phase(u_ctrl.row_phase),
        .input_read_data(input_read_data), .window(window)
    );

    conv_datapath u_datapath (
        .clk(clk), .reset_b(reset_b), .ctrl(u_ctrl.dp), .kernel(kernel),
        .window(window), .input_read_data(input_read_data), .acc(acc)
    );

    pool_writer u_pool_writer (
        .clk(clk), .reset_b(reset_b), .ctrl(u_ctrl.pool), .acc(acc),
        .output_write_enable(output_write_enable),
        .output_write_address(output_write_address),
        .output_write_data(output_write_data)
    );

endmodule

`default_nettype wire

// File: cnn_pkg.sv
`default_nettype none

`include "cnn_settings.svh"

package cnn_pkg;

    typedef logic [`CNN_ADDR_W-1:0] addr_t;
    typedef logic [`CNN_DATA_W-1:0] word_t;
    typedef logic signed [`CNN_PIX_W-1:0] pixel_t;
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;
    typedef logic [`CNN_PIX_W-1:0] size_t;   // image side and strip counters

    // index 0 is the top left tap, row-major
    typedef pixel_t [0:8] kernel_t;
    // high and low pixel per row of the previous word column
    typedef pixel_t [0:7] window_t;
    // upper left, upper right, lower left, lower right
    typedef acc_t [0:3] acc_quad_t;

    typedef enum logic [2:0] {
        s_idle, s_load_kernel, s_read_size, s_row0, s_row1, s_row2, s_row3
    } seq_state_t;

endpackage

`default_nettype wire

// File: cnn_settings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// sram geometry
`define CNN_ADDR_W 12
`define CNN_DATA_W 16

// arithmetic widths
`define CNN_PIX_W 8
`define CNN_ACC_W 20

// kernel is 9 bytes in 5 words, last byte spare
`define CNN_KERNEL_WORDS 5

`define CNN_PIX_MAX 127          // clamp ceiling of a pooled value
`define CNN_END_MARK 16'hffff    // size word that ends the image sequence

`endif

// File: conv_ctrl_if.sv
`default_nettype none

// per-cycle control from the sequencer
interface conv_ctrl_if;

    logic [3:0] row_phase;     // bit r set while row r returns from the input sram
    logic [3:0] acc_enable;    // bit j enables accumulator j
    logic       acc_restart;   // load instead of add
    logic       pool_go;       // one pulse per finished 2x2 group
    logic       end_image;     // marks pool_go of the last group of an image
    logic       idle;

    modport seq (
        output row_phase, acc_enable, acc_restart, pool_go, end_image, idle
    );

    modport dp (input row_phase, acc_enable, acc_restart);

    modport pool (input pool_go, end_image, idle);

endinterface

`default_nettype wire

// File: conv_datapath.sv
`default_nettype none

module conv_datapath import cnn_pkg::*; (
    input  wire           clk,
    input  wire           reset_b,
    conv_ctrl_if.dp       ctrl,
    input  wire kernel_t  kernel,
    input  wire window_t  window,
    input  wire word_t    input_read_data,
    output acc_quad_t     acc
);

    localparam int prod_w = 2 * $bits(pixel_t);

    logic [1:0]               phase;
    logic [1:0]               row_upper;    // kernel row for accumulators 0 and 1
    logic [1:0]               row_lower;    // one row behind the upper pair
    pixel_t                   in_hi, in_lo;
    pixel_t                   px [0:3];     // stored pair then arriving pair
    pixel_t                   kx [0:3][0:2];
    logic signed [prod_w-1:0] prod [0:11];
    acc_t                     sum [0:3];

    assign {in_hi, in_lo} = input_read_data;

    always_comb begin
        phase = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (ctrl.row_phase[i]) phase = 2'(i);
        end
        row_upper = (phase == 2'd3) ? 2'd0 : phase;
        row_lower = (phase == 2'd0) ? 2'd0 : phase - 2'd1;
    end

    // ----------------------------------------
    // operand selection and products
    // ----------------------------------------
    always_comb begin
        px[0] = window[{phase, 1'b0}];
        px[1] = window[{phase, 1'b1}];
        px[2] = in_hi;
        px[3] = in_lo;
        for (int j = 0; j < 4; j++) begin
            for (int t = 0; t < 3; t++) begin
                kx[j][t] = (j < 2) ? kernel[3 * row_upper + t] : kernel[3 * row_lower + t];
                prod[3 * j + t] = kx[j][t] * px[(j % 2) + t];   // right column shifted by one
            end
            sum[j] = prod[3 * j] + prod[3 * j + 1] + prod[3 * j + 2];
        end
    end

    // restart clears the disabled ones too
    always_ff @(posedge clk) begin
        if (reset_b) begin
            acc <= '0;
        end else begin
            for (int j = 0; j < 4; j++) begin
                if (ctrl.acc_restart) begin
                    acc[j] <= ctrl.acc_enable[j] ? sum[j] : '0;
                end else if (ctrl.acc_enable[j]) begin
                    acc[j] <= acc[j] + sum[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: conv_sequencer.sv
`default_nettype none

`include "cnn_settings.svh"

module conv_sequencer import cnn_pkg::*; (
    input  wire         clk,
    input  wire         reset_b,
    input  wire         dut_run,
    input  wire         kernel_done,
    input  wire word_t  input_read_data,
    output addr_t       input_read_address,
    output logic        kernel_start,
    output logic        dut_busy,
    conv_ctrl_if.seq    ctrl
);

    seq_state_t state, state_next;
    size_t      size, half;
    size_t      row_cnt, col_cnt;       // pool row and word column within the strip
    addr_t      origin, origin_next;    // word of row0 in the current column
    logic       last_col, last_row, end_mark;

    assign half     = size >> 1;
    assign last_col = (col_cnt == half - size_t'(1));
    assign last_row = (row_cnt == half - size_t'(2));
    assign end_mark = (input_read_data == `CNN_END_MARK);

    assign kernel_start = (state == s_idle) && dut_run;

    // ----------------------------------------
    // next state and read address
    // ----------------------------------------
    always_comb begin
        state_next = state;
        origin_next = origin;
        input_read_address = origin;
        unique case (state)
            s_idle: begin
                origin_next = '0;
                if (dut_run) state_next = s_load_kernel;
            end
            s_load_kernel: begin
                if (kernel_done) state_next = s_read_size;   // size word of image 0 arrives then
            end
            s_read_size: begin
                if (end_mark) begin
                    state_next = s_idle;
                end else begin
                    state_next = s_row0;
                    origin_next = origin + 1'b1;
                    input_read_address = origin + 1'b1;
                end
            end
            s_row0: begin
                state_next = s_row1;
                input_read_address = origin + addr_t'(half);
            end
            s_row1: begin
                state_next = s_row2;
                input_read_address = origin + addr_t'(size);
            end
            s_row2: begin
                state_next = s_row3;
                input_read_address = origin + addr_t'(size) + addr_t'(half);
            end
            s_row3: begin
                state_next = s_row0;
                if (!last_col) begin
                    origin_next = origin + 1'b1;
                end else if (!last_row) begin
                    origin_next = origin + addr_t'(half) + 1'b1;   // two image rows down
                end else begin
                    // skip the last two rows, land on the next size word
                    origin_next = origin + addr_t'(size) + addr_t'(half) + 1'b1;
                    state_next = s_read_size;
                end
                input_read_address = origin_next;
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_b) begin
            state <= s_idle;
            origin <= '0;
            size <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            dut_busy <= 1'b0;
            ctrl.pool_go <= 1'b0;
            ctrl.end_image <= 1'b0;
        end else begin
            state <= state_next;
            origin <= origin_next;
            dut_busy <= (state != s_idle) || dut_run;   // covers the final pool write
            ctrl.pool_go <= (state == s_row3) && (col_cnt != '0);
            ctrl.end_image <= (state == s_row3) && last_col && last_row;
            if (state == s_read_size) begin
                size <= size_t'(input_read_data);
                row_cnt <= '0;
                col_cnt <= '0;
            end else if (state == s_row3) begin
                if (!last_col) begin
                    col_cnt <= col_cnt + 1'b1;
                end else begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // datapath steering
    // ----------------------------------------
    assign ctrl.idle = (state == s_idle);
    assign ctrl.acc_restart = (state == s_row0);

    always_comb begin
        ctrl.row_phase = 4'b0000;
        ctrl.acc_enable = 4'b0000;
        unique case (state)
            s_row0: begin
                ctrl.row_phase = 4'b0001;
                ctrl.acc_enable = 4'b0011;   // lower pair starts on row1
            end
            s_row1: begin
                ctrl.row_phase = 4'b0010;
                ctrl.acc_enable = 4'b1111;
            end
            s_row2: begin
                ctrl.row_phase = 4'b0100;
                ctrl.acc_enable = 4'b1111;
            end
            s_row3: begin
                ctrl.row_phase = 4'b1000;
                ctrl.acc_enable = 4'b1100;
            end
            default: ;
        endcase
        if (col_cnt == '0) ctrl.acc_enable = 4'b0000;   // first column only fills the window
    end

endmodule

`default_nettype wire

// File: kernel_loader.sv
`default_nettype none

`include "cnn_settings.svh"

module kernel_loader import cnn_pkg::*; (
    input  wire         clk,
    input  wire         reset_b,
    input  wire         start,
    input  wire word_t  weights_read_data,
    output addr_t       weights_read_address,
    output logic        done,
    output kernel_t     kernel
);

    localparam addr_t last_addr = addr_t'(`CNN_KERNEL_WORDS - 1);

    logic          fetching;
    logic          shift_en;       // read data valid this cycle
    pixel_t [0:9]  chain;
    pixel_t        hi, lo;

    assign {hi, lo} = weights_read_data;

    always_ff @(posedge clk) begin
        if (reset_b) begin
            fetching <= 1'b0;
            shift_en <= 1'b0;
            weights_read_address <= '0;
        end else begin
            shift_en <= fetching;
            if (start) begin
                fetching <= 1'b1;
                weights_read_address <= '0;
            end else if (fetching) begin
                if (weights_read_address == last_addr) fetching <= 1'b0;
                else weights_read_address <= weights_read_address + 1'b1;
            end
        end
    end

    // high byte enters ahead of the low byte
    always_ff @(posedge clk) begin
        if (shift_en) chain <= {chain[2:9], hi, lo};
    end

    assign done = shift_en && !fetching;   // last word shifting in
    assign kernel = chain[0:8];

endmodule

`default_nettype wire

// File: pool_writer.sv
`default_nettype none

`include "cnn_settings.svh"

module pool_writer import cnn_pkg::*; (
    input  wire             clk,
    input  wire             reset_b,
    conv_ctrl_if.pool       ctrl,
    input  wire acc_quad_t  acc,
    output logic            output_write_enable,
    output addr_t           output_write_address,
    output word_t           output_write_data
);

    acc_t   a [0:3];
    acc_t   max_upper, max_lower, max_all;
    pixel_t pooled;
    logic   half;       // high byte holds a value waiting for its partner

    // ----------------------------------------
    // 2x2 max and clamp
    // ----------------------------------------
    always_comb begin
        for (int j = 0; j < 4; j++) a[j] = acc[j];
        max_upper = (a[0] >= a[1]) ? a[0] : a[1];
        max_lower = (a[2] >= a[3]) ? a[2] : a[3];
        max_all = (max_upper >= max_lower) ? max_upper : max_lower;
        if (max_all <= 0) pooled = '0;
        else if (max_all >= `CNN_PIX_MAX) pooled = pixel_t'(`CNN_PIX_MAX);
        else pooled = max_all[`CNN_PIX_W-1:0];
    end

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_b) begin
            output_write_enable <= 1'b0;
            output_write_address <= '1;
            half <= 1'b0;
        end else begin
            output_write_enable <= 1'b0;
            if (ctrl.idle) begin
                output_write_address <= '1;   // first write lands on 0
                half <= 1'b0;
            end else if (ctrl.pool_go) begin
                if (!half) output_write_address <= output_write_address + 1'b1;
                if (half || ctrl.end_image) output_write_enable <= 1'b1;
                half <= !half && !ctrl.end_image;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.pool_go) begin
            if (!half) begin
                output_write_data <= {pooled, {`CNN_PIX_W{1'b0}}};   // low byte zero until filled
            end else begin
                output_write_data[`CNN_PIX_W-1:0] <= pooled;
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
cnn_pkg.sv
conv_ctrl_if.sv
conv_sequencer.sv
kernel_loader.sv
window_buffer.sv
conv_datapath.sv
pool_writer.sv
cnn_accel_top.sv
cnn_accel_chk.sv
tb_cnn_accel.sv

// File: tb_cnn_accel.sv
`default_nettype none

`include "cnn_settings.svh"

module tb_cnn_accel import cnn_pkg::*; ();

    localparam int mem_words = 1 << `CNN_ADDR_W;

    logic  clk;
    logic  reset_b;
    logic  dut_run;
    logic  dut_busy;
    logic  input_write_enable, weights_write_enable, output_write_enable;
    addr_t input_write_address, input_read_address;
    addr_t weights_write_address, weights_read_address;
    addr_t output_write_address, output_read_address;
    word_t input_write_data, weights_write_data, output_write_data;
    word_t input_read_data, weights_read_data, output_read_data;

    word_t  input_mem [0:mem_words-1];
    word_t  weights_mem [0:mem_words-1];
    word_t  output_mem [0:mem_words-1];

    int     kern [0:9];        // nine taps row-major, tenth byte spare
    int     img [0:7][0:7];
    word_t  exp_words [$];     // expected output words of one run
    int     in_ptr;            // next free input word
    int     wr_idx;
    int     run_count;
    logic   loaded;
    integer seed;

    cnn_accel_top u_dut (
        .clk(clk), .reset_b(reset_b), .dut_run(dut_run), .dut_busy(dut_busy),
        .input_write_enable(input_write_enable), .input_write_address(input_write_address),
        .input_write_data(input_write_data), .input_read_address(input_read_address),
        .input_read_data(input_read_data),
        .weights_write_enable(weights_write_enable),
        .weights_write_address(weights_write_address),
        .weights_write_data(weights_write_data), .weights_read_address(weights_read_address),
        .weights_read_data(weights_read_data),
        .output_write_enable(output_write_enable), .output_write_address(output_write_address),
        .output_write_data(output_write_data), .output_read_address(output_read_address),
        .output_read_data(output_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sram models, one cycle read latency
    always @(posedge clk) begin
        input_read_data <= input_mem[input_read_address];
        weights_read_data <= weights_mem[weights_read_address];
        output_read_data <= output_mem[output_read_address];
        if (input_write_enable) input_mem[input_write_address] <= input_write_data;
        if (weights_write_enable) weights_mem[weights_write_address] <= weights_write_data;
        if (output_write_enable) output_mem[output_write_address] <= output_write_data;
    end

    task automatic flag_mismatch(input string name, input int expected, input int actual);
        $display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "value check");
    endtask

    task automatic abort_run(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "protocol check");
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic int conv_at(input int r, input int c);
        int s, ky, kx;
        s = 0;
        for (ky = 0; ky < 3; ky++) begin
            for (kx = 0; kx < 3; kx++) s += kern[3 * ky + kx] * img[r + ky][c + kx];
        end
        return s;
    endfunction

    // stores one image after the previous one and appends its expected words
    task automatic add_image(input int n, input logic random_fill);
        int         y, x, best, i;
        pixel_t     b;
        logic [7:0] pooled [$];
        for (y = 0; y < n; y++) begin
            for (x = 0; x < n; x++) begin
                if (!random_fill) begin
                    b = pixel_t'((3 * y + 5 * x) % 23 - 6);
                end else if (y < 4 && x < 4) begin
                    b = pixel_t'(-100);   // whole first pool negative
                end else if (y > 4 && x > 4) begin
                    b = pixel_t'(100);    // last pool well above the ceiling
                end else begin
                    b = pixel_t'($random(seed));
                end
                img[y][x] = b;
            end
        end
        input_mem[in_ptr] = {8'h00, 8'(n)};   // size word
        in_ptr++;
        for (y = 0; y < n; y++) begin
            for (x = 0; x < n; x += 2) begin
                input_mem[in_ptr] = {8'(img[y][x]), 8'(img[y][x + 1])};
                in_ptr++;
            end
        end
        for (y = 0; y < (n - 2) / 2; y++) begin
            for (x = 0; x < (n - 2) / 2; x++) begin
                best = conv_at(2 * y, 2 * x);
                if (conv_at(2 * y, 2 * x + 1) > best) best = conv_at(2 * y, 2 * x + 1);
                if (conv_at(2 * y + 1, 2 * x) > best) best = conv_at(2 * y + 1, 2 * x);
                if (conv_at(2 * y + 1, 2 * x + 1) > best) best = conv_at(2 * y + 1, 2 * x + 1);
                if (best <= 0) best = 0;
                else if (best >= `CNN_PIX_MAX) best = `CNN_PIX_MAX;
                pooled.push_back(8'(best));
            end
        end
        for (i = 0; i < pooled.size(); i += 2) begin
            if (i + 1 < pooled.size()) exp_words.push_back({pooled[i], pooled[i + 1]});
            else exp_words.push_back({pooled[i], 8'h00});   // odd count pads the low byte
        end
    endtask

    // ----------------------------------------
    // output checks
    // ----------------------------------------
    always @(negedge clk) begin
        if (!reset_b) begin
            assert (u_dut.u_chk.error_count == 0)
                else abort_run("bound assertion on the write port or busy protocol failed");
            assert (!input_write_enable && !weights_write_enable)
                else abort_run("write to a read-only SRAM");
            if (output_write_enable) begin
                assert (run_count > 0) else abort_run("output write before dut_run");
                assert (wr_idx < exp_words.size()) else abort_run("too many output writes");
                assert (output_write_address == addr_t'(wr_idx))
                    else flag_mismatch("output_write_address", wr_idx, output_write_address);
                assert (output_write_data == exp_words[wr_idx])
                    else flag_mismatch("output_write_data", exp_words[wr_idx], output_write_data);
                wr_idx++;
            end
        end
    end

    task automatic run_once();
        wr_idx = 0;
        assert (!dut_busy) else abort_run("dut_busy high before dut_run");
        dut_run = 1'b1;
        run_count++;
        @(negedge clk);
        dut_run = 1'b0;
        assert (dut_busy) else abort_run("dut_busy did not rise after dut_run");
        while (dut_busy) @(negedge clk);
        assert (wr_idx == exp_words.size())
            else flag_mismatch("output write count", exp_words.size(), wr_idx);
    endtask

    initial begin
        int i;
        seed = 32'h3f2e6511;
        reset_b = 1'b1;
        dut_run = 1'b0;
        input_read_data = '0;
        weights_read_data = '0;
        output_read_data = '0;
        wr_idx = 0;
        run_count = 0;
        in_ptr = 0;
        loaded = 1'b0;
        for (i = 0; i < mem_words; i++) begin
            input_mem[i] = word_t'(i) ^ 16'hc3a5;
            weights_mem[i] = word_t'(i) ^ 16'h3c5a;
        end
        kern = '{2, -1, 0, 1, 3, -2, 0, 1, -1, 92};
        for (i = 0; i < `CNN_KERNEL_WORDS; i++) begin
            weights_mem[i] = {8'(kern[2 * i]), 8'(kern[2 * i + 1])};
        end
        add_image(4, 1'b0);
        add_image(6, 1'b0);
        add_image(8, 1'b1);
        input_mem[in_ptr] = `CNN_END_MARK;
        in_ptr++;
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        reset_b = 1'b0;
        @(negedge clk);
        assert (!dut_busy) else abort_run("dut_busy high after reset");
        run_once();
        repeat (6) @(negedge clk);
        run_once();   // same words again from address 0
        repeat (4) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog scaled by the size of the input data
    initial begin
        wait (loaded);
        repeat (50 * in_ptr + 200) @(posedge clk);
        $display("Timeout: the DUT did not finish within %0d cycles", 50 * in_ptr + 200);
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

// File: window_buffer.sv
`default_nettype none

module window_buffer import cnn_pkg::*; (
    input  wire         clk,
    input  wire         reset_b,
    input  wire [3:0]   row_phase,
    input  wire word_t  input_read_data,
    output window_t     window
);

    pixel_t hi, lo;

    assign {hi, lo} = input_read_data;

    // each row keeps its pair until the same row of the next column returns
    always_ff @(posedge clk) begin
        if (reset_b) begin
            window <= '0;
        end else begin
            for (int r = 0; r < 4; r++) begin
                if (row_phase[r]) begin
                    window[2 * r] <= hi;
                    window[2 * r + 1] <= lo;
                end
            end
        end
    end

endmodule

`default_nettype wire
